/* source/axil_pkg.sv */
// AXI-Lite bus widths and response code enum
`default_nettype none

package axil_pkg;

  // Bus widths for the single-beat OCL port
  localparam int addr_width = 32;
  localparam int data_width = 32;

  // One strobe per data byte
  localparam int strb_width = data_width / 8;

  // Response codes on bresp and rresp
  // Only OKAY is ever issued by this design
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

endpackage

`default_nettype wire

/* source/hello_regs_pkg.sv */
// Register map, constant read values and slave FSM state enums
`default_nettype none

package hello_regs_pkg;

  // Register offsets within the OCL window
  localparam logic [axil_pkg::addr_width-1:0] hello_world_addr = 32'h0000_0500;
  localparam logic [axil_pkg::addr_width-1:0] vled_addr        = 32'h0000_0504;
  localparam logic [axil_pkg::addr_width-1:0] design_id_addr   = 32'h0000_0508;

  // Fixed read values
  localparam logic [axil_pkg::data_width-1:0] design_id_value     = 32'hF000_1D0F;
  localparam logic [axil_pkg::data_width-1:0] unimplemented_value = 32'hDEAD_DEAD;

  // Virtual LED and DIP switch count
  localparam int vled_width = 16;

  // Write path FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // Read path FSM
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_LOOKUP,
    RD_RESP
  } rd_state_e;

endpackage

`default_nettype wire

/* source/axil_if.sv */
// AXI-Lite interface with master and slave modports
`timescale 1ns/100ps
`default_nettype none

interface axil_if;

  // Write address channel
  logic                                awvalid;
  logic [axil_pkg::addr_width-1:0]     awaddr;
  logic                                awready;

  // Write data channel
  logic                                wvalid;
  logic [axil_pkg::data_width-1:0]     wdata;
  logic [axil_pkg::strb_width-1:0]     wstrb;
  logic                                wready;

  // Write response channel
  logic                                bvalid;
  axil_pkg::resp_e                     bresp;
  logic                                bready;

  // Read address channel
  logic                                arvalid;
  logic [axil_pkg::addr_width-1:0]     araddr;
  logic                                arready;

  // Read data channel
  logic                                rvalid;
  logic [axil_pkg::data_width-1:0]     rdata;
  axil_pkg::resp_e                     rresp;
  logic                                rready;

  // Initiator side
  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  // Target side
  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

`default_nettype wire

/* source/reg_access_if.sv */
// Simple register access interface with requester and responder modports
`timescale 1ns/100ps
`default_nettype none

interface reg_access_if;

  // Write side, wr_en is a single-cycle pulse
  logic                                wr_en;
  logic [axil_pkg::addr_width-1:0]     wr_addr;
  logic [axil_pkg::data_width-1:0]     wr_data;
  logic [axil_pkg::strb_width-1:0]     wr_strb;

  // Read side, rd_data is combinational from rd_addr
  logic [axil_pkg::addr_width-1:0]     rd_addr;
  logic [axil_pkg::data_width-1:0]     rd_data;

  modport requester (
    output wr_en, wr_addr, wr_data, wr_strb, rd_addr,
    input  rd_data
  );

  modport responder (
    input  wr_en, wr_addr, wr_data, wr_strb, rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

/* source/axil_reg_slice.sv */
// One-entry AXI-Lite register slice on all five channels
`timescale 1ns/100ps
`default_nettype none

module axil_reg_slice (
  input  logic   clk_main_a0,
  input  logic   rst_main_n_sync,
  axil_if.slave  up,
  axil_if.master down
);

  // Stage occupancy flags
  logic aw_full;
  logic w_full;
  logic b_full;
  logic ar_full;
  logic r_full;

  // Stored beats
  logic [axil_pkg::addr_width-1:0] aw_addr_q;
  logic [axil_pkg::data_width-1:0] w_data_q;
  logic [axil_pkg::strb_width-1:0] w_strb_q;
  axil_pkg::resp_e                 b_resp_q;
  logic [axil_pkg::addr_width-1:0] ar_addr_q;
  logic [axil_pkg::data_width-1:0] r_data_q;
  axil_pkg::resp_e                 r_resp_q;

  // Beat accepted into each stage this cycle
  logic aw_in;
  logic w_in;
  logic b_in;
  logic ar_in;
  logic r_in;

  // ----------------------------------------------------------
  // Ready when empty or when the held beat leaves this edge
  // ----------------------------------------------------------
  assign up.awready  = !aw_full || down.awready;
  assign up.wready   = !w_full  || down.wready;
  assign down.bready = !b_full  || up.bready;
  assign up.arready  = !ar_full || down.arready;
  assign down.rready = !r_full  || up.rready;

  assign aw_in = up.awvalid  && up.awready;
  assign w_in  = up.wvalid   && up.wready;
  assign b_in  = down.bvalid && down.bready;
  assign ar_in = up.arvalid  && up.arready;
  assign r_in  = down.rvalid && down.rready;

  // Request channels toward the slave
  assign down.awvalid = aw_full;
  assign down.awaddr  = aw_addr_q;
  assign down.wvalid  = w_full;
  assign down.wdata   = w_data_q;
  assign down.wstrb   = w_strb_q;
  assign down.arvalid = ar_full;
  assign down.araddr  = ar_addr_q;

  // Response channels back toward the host
  assign up.bvalid = b_full;
  assign up.bresp  = b_resp_q;
  assign up.rvalid = r_full;
  assign up.rdata  = r_data_q;
  assign up.rresp  = r_resp_q;

  // ----------------------------------------------------------
  // Occupancy, a new beat wins over a departing one
  // ----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      b_full  <= 1'b0;
      ar_full <= 1'b0;
      r_full  <= 1'b0;
    end else begin
      if (aw_in) begin
        aw_full <= 1'b1;
      end else if (down.awready) begin
        aw_full <= 1'b0;
      end
      if (w_in) begin
        w_full <= 1'b1;
      end else if (down.wready) begin
        w_full <= 1'b0;
      end
      if (b_in) begin
        b_full <= 1'b1;
      end else if (up.bready) begin
        b_full <= 1'b0;
      end
      if (ar_in) begin
        ar_full <= 1'b1;
      end else if (down.arready) begin
        ar_full <= 1'b0;
      end
      if (r_in) begin
        r_full <= 1'b1;
      end else if (up.rready) begin
        r_full <= 1'b0;
      end
    end
  end

  // Payload capture on acceptance only
  always_ff @(posedge clk_main_a0) begin
    if (aw_in) begin
      aw_addr_q <= up.awaddr;
    end
    if (w_in) begin
      w_data_q <= up.wdata;
      w_strb_q <= up.wstrb;
    end
    if (b_in) begin
      b_resp_q <= down.bresp;
    end
    if (ar_in) begin
      ar_addr_q <= up.araddr;
    end
    if (r_in) begin
      r_data_q <= down.rdata;
      r_resp_q <= down.rresp;
    end
  end

endmodule

`default_nettype wire

/* source/axil_reg_slave.sv */
// AXI-Lite slave with independent write and read FSMs driving register accesses
`timescale 1ns/100ps
`default_nettype none

module axil_reg_slave (
  input  logic            clk_main_a0,
  input  logic            rst_main_n_sync,
  axil_if.slave           axil,
  reg_access_if.requester regs
);

  hello_regs_pkg::wr_state_e wr_state_q;
  hello_regs_pkg::rd_state_e rd_state_q;

  // Latched addresses and read data
  logic [axil_pkg::addr_width-1:0] wr_addr_q;
  logic [axil_pkg::addr_width-1:0] rd_addr_q;
  logic [axil_pkg::data_width-1:0] rdata_q;

  // ----------------------------------------------------------
  // Write path
  // ----------------------------------------------------------
  assign axil.awready = (wr_state_q == hello_regs_pkg::WR_IDLE);
  assign axil.wready  = (wr_state_q == hello_regs_pkg::WR_DATA) && axil.wvalid;
  assign axil.bvalid  = (wr_state_q == hello_regs_pkg::WR_RESP);
  assign axil.bresp   = axil_pkg::OKAY;

  // Register write fires with the w transfer
  assign regs.wr_en   = axil.wready;
  assign regs.wr_addr = wr_addr_q;
  assign regs.wr_data = axil.wdata;
  assign regs.wr_strb = axil.wstrb;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state_q <= hello_regs_pkg::WR_IDLE;
    end else begin
      case (wr_state_q)
        hello_regs_pkg::WR_IDLE: begin
          if (axil.awvalid) begin
            wr_state_q <= hello_regs_pkg::WR_DATA;
          end
        end
        hello_regs_pkg::WR_DATA: begin
          if (axil.wvalid) begin
            wr_state_q <= hello_regs_pkg::WR_RESP;
          end
        end
        hello_regs_pkg::WR_RESP: begin
          if (axil.bready) begin
            wr_state_q <= hello_regs_pkg::WR_IDLE;
          end
        end
        default: wr_state_q <= hello_regs_pkg::WR_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------
  assign axil.arready = (rd_state_q == hello_regs_pkg::RD_IDLE);
  assign axil.rvalid  = (rd_state_q == hello_regs_pkg::RD_RESP);
  assign axil.rdata   = rdata_q;
  assign axil.rresp   = axil_pkg::OKAY;
  assign regs.rd_addr = rd_addr_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state_q <= hello_regs_pkg::RD_IDLE;
    end else begin
      case (rd_state_q)
        hello_regs_pkg::RD_IDLE: begin
          if (axil.arvalid) begin
            rd_state_q <= hello_regs_pkg::RD_LOOKUP;
          end
        end
        // Single lookup cycle
        hello_regs_pkg::RD_LOOKUP: rd_state_q <= hello_regs_pkg::RD_RESP;
        hello_regs_pkg::RD_RESP: begin
          if (axil.rready) begin
            rd_state_q <= hello_regs_pkg::RD_IDLE;
          end
        end
        default: rd_state_q <= hello_regs_pkg::RD_IDLE;
      endcase
    end
  end

  // Address latches and read data capture
  always_ff @(posedge clk_main_a0) begin
    if (axil.awvalid && axil.awready) begin
      wr_addr_q <= axil.awaddr;
    end
    if (axil.arvalid && axil.arready) begin
      rd_addr_q <= axil.araddr;
    end
    if (rd_state_q == hello_regs_pkg::RD_LOOKUP) begin
      rdata_q <= regs.rd_data;
    end
  end

endmodule

`default_nettype wire

/* source/hello_reg_file.sv */
// Scratch, virtual LED and ID registers with read decode and LED masking
`timescale 1ns/100ps
`default_nettype none

module hello_reg_file (
  input  logic                                  clk_main_a0,
  input  logic                                  rst_main_n_sync,
  reg_access_if.responder                       regs,
  input  logic [hello_regs_pkg::vled_width-1:0] status_vdip,
  output logic [hello_regs_pkg::vled_width-1:0] status_vled
);

  logic [axil_pkg::data_width-1:0]     scratch_q;
  logic [axil_pkg::data_width-1:0]     scratch_swapped;
  logic [hello_regs_pkg::vled_width-1:0] vled_q;
  logic                                scratch_wr;

  // ----------------------------------------------------------
  // Scratch word
  // ----------------------------------------------------------
  assign scratch_wr = regs.wr_en && (regs.wr_addr == hello_regs_pkg::hello_world_addr);

  // Byte-wise update under strobes
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      scratch_q <= '0;
    end else if (scratch_wr) begin
      for (int i = 0; i < axil_pkg::strb_width; i++) begin
        if (regs.wr_strb[i]) begin
          scratch_q[8*i +: 8] <= regs.wr_data[8*i +: 8];
        end
      end
    end
  end

  // Reads come back byte-reversed
  assign scratch_swapped = {scratch_q[7:0], scratch_q[15:8], scratch_q[23:16], scratch_q[31:24]};

  // LED shadow, one edge behind scratch
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
    end else begin
      vled_q <= scratch_q[hello_regs_pkg::vled_width-1:0];
    end
  end

  // DIP switches gate the LEDs
  assign status_vled = vled_q & status_vdip;

  // ----------------------------------------------------------
  // Read decode
  // ----------------------------------------------------------
  always_comb begin
    case (regs.rd_addr)
      hello_regs_pkg::hello_world_addr: regs.rd_data = scratch_swapped;
      hello_regs_pkg::vled_addr: begin
        regs.rd_data = {{(axil_pkg::data_width - hello_regs_pkg::vled_width){1'b0}}, vled_q};
      end
      hello_regs_pkg::design_id_addr: regs.rd_data = hello_regs_pkg::design_id_value;
      default: regs.rd_data = hello_regs_pkg::unimplemented_value;
    endcase
  end

endmodule

`default_nettype wire

/* source/hello_world_top.sv */
// Top level with OCL AXI-Lite ports, register slice, slave and register file
`timescale 1ns/100ps
`default_nettype none

module hello_world_top (
  input  logic                                  clk_main_a0,
  input  logic                                  rst_main_n_sync,
  // AXI-Lite slave port
  input  logic                                  ocl_awvalid,
  input  logic [axil_pkg::addr_width-1:0]       ocl_awaddr,
  output logic                                  ocl_awready,
  input  logic                                  ocl_wvalid,
  input  logic [axil_pkg::data_width-1:0]       ocl_wdata,
  input  logic [axil_pkg::strb_width-1:0]       ocl_wstrb,
  output logic                                  ocl_wready,
  output logic                                  ocl_bvalid,
  output logic [1:0]                            ocl_bresp,
  input  logic                                  ocl_bready,
  input  logic                                  ocl_arvalid,
  input  logic [axil_pkg::addr_width-1:0]       ocl_araddr,
  output logic                                  ocl_arready,
  output logic                                  ocl_rvalid,
  output logic [axil_pkg::data_width-1:0]       ocl_rdata,
  output logic [1:0]                            ocl_rresp,
  input  logic                                  ocl_rready,
  // Virtual switches and LEDs
  input  logic [hello_regs_pkg::vled_width-1:0] status_vdip,
  output logic [hello_regs_pkg::vled_width-1:0] status_vled
);

  axil_if       slice_in ();
  axil_if       slice_out ();
  reg_access_if reg_bus ();

  // Host side of the slice
  assign slice_in.awvalid = ocl_awvalid;
  assign slice_in.awaddr  = ocl_awaddr;
  assign slice_in.wvalid  = ocl_wvalid;
  assign slice_in.wdata   = ocl_wdata;
  assign slice_in.wstrb   = ocl_wstrb;
  assign slice_in.bready  = ocl_bready;
  assign slice_in.arvalid = ocl_arvalid;
  assign slice_in.araddr  = ocl_araddr;
  assign slice_in.rready  = ocl_rready;
  assign ocl_awready      = slice_in.awready;
  assign ocl_wready       = slice_in.wready;
  assign ocl_bvalid       = slice_in.bvalid;
  assign ocl_bresp        = slice_in.bresp;
  assign ocl_arready      = slice_in.arready;
  assign ocl_rvalid       = slice_in.rvalid;
  assign ocl_rdata        = slice_in.rdata;
  assign ocl_rresp        = slice_in.rresp;

  // Retiming stage on every channel
  axil_reg_slice u_slice (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .up              (slice_in.slave),
    .down            (slice_out.master)
  );

  axil_reg_slave u_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil            (slice_out.slave),
    .regs            (reg_bus.requester)
  );

  hello_reg_file u_reg_file (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .regs            (reg_bus.responder),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

endmodule

`default_nettype wire

/* tb/hello_world_assertions.sv */
// Bound concurrent checks on the top-level AXI-Lite handshakes and reset state
`timescale 1ns/100ps
`default_nettype none

module hello_world_assertions (
  input logic        clk_main_a0,
  input logic        rst_main_n_sync,
  input logic        ocl_awvalid,
  input logic [31:0] ocl_awaddr,
  input logic        ocl_awready,
  input logic        ocl_wvalid,
  input logic [31:0] ocl_wdata,
  input logic [3:0]  ocl_wstrb,
  input logic        ocl_wready,
  input logic        ocl_bvalid,
  input logic [1:0]  ocl_bresp,
  input logic        ocl_bready,
  input logic        ocl_arvalid,
  input logic [31:0] ocl_araddr,
  input logic        ocl_arready,
  input logic        ocl_rvalid,
  input logic [31:0] ocl_rdata,
  input logic [1:0]  ocl_rresp,
  input logic        ocl_rready
);

  // ----------------------------------------------------------
  // Valid and payload hold until the transfer
  // ----------------------------------------------------------
  aw_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_awvalid && !ocl_awready |=> ocl_awvalid && $stable(ocl_awaddr))
    else $error("awvalid or awaddr changed before awready");

  w_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_wvalid && !ocl_wready |=> ocl_wvalid && $stable(ocl_wdata) && $stable(ocl_wstrb))
    else $error("wvalid or write payload changed before wready");

  // Response side, driven by the DUT
  b_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_bvalid && !ocl_bready |=> ocl_bvalid && $stable(ocl_bresp))
    else $error("bvalid or bresp changed before bready");

  ar_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_arvalid && !ocl_arready |=> ocl_arvalid && $stable(ocl_araddr))
    else $error("arvalid or araddr changed before arready");

  r_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_rvalid && !ocl_rready |=> ocl_rvalid && $stable(ocl_rdata) && $stable(ocl_rresp))
    else $error("rvalid or read payload changed before rready");

  // All valids low once reset has been seen on an edge
  reset_quiet: assert property (@(posedge clk_main_a0)
    !rst_main_n_sync && $past(!rst_main_n_sync) |->
      !(ocl_awvalid || ocl_wvalid || ocl_arvalid || ocl_bvalid || ocl_rvalid))
    else $error("valid signal high during reset");

endmodule

`default_nettype wire

/* tb/hello_world_tb.sv */
// Testbench with clock, reset, random AXI-Lite traffic, reference model and watchdog
`timescale 1ns/100ps
`default_nettype none

module hello_world_tb;

  localparam int          clk_period       = 100;
  localparam int          num_trans        = 400;
  localparam int          cycles_per_trans = 40;
  localparam logic [31:0] exp_design_id    = 32'hF000_1D0F;
  localparam logic [31:0] exp_unimpl       = 32'hDEAD_DEAD;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        ocl_awvalid;
  logic [31:0] ocl_awaddr;
  logic        ocl_awready;
  logic        ocl_wvalid;
  logic [31:0] ocl_wdata;
  logic [3:0]  ocl_wstrb;
  logic        ocl_wready;
  logic        ocl_bvalid;
  logic [1:0]  ocl_bresp;
  logic        ocl_bready;
  logic        ocl_arvalid;
  logic [31:0] ocl_araddr;
  logic        ocl_arready;
  logic        ocl_rvalid;
  logic [31:0] ocl_rdata;
  logic [1:0]  ocl_rresp;
  logic        ocl_rready;
  logic [15:0] status_vdip;
  logic [15:0] status_vled;

  int          data_errors;
  int          protocol_errors;
  // Reference copy of the scratch word
  logic [31:0] model_scratch;

  hello_world_top hello_world_top_inst (.*);

  bind hello_world_top hello_world_assertions hello_world_assertions_inst (.*);

  initial begin
    clk_main_a0 = 1'b0;
    forever #(clk_period / 2) clk_main_a0 = ~clk_main_a0;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  // One rising edge with fresh random response readies
  task automatic tick();
    @(posedge clk_main_a0);
    ocl_bready <= 1'($urandom_range(0, 1));
    ocl_rready <= 1'($urandom_range(0, 1));
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      data_errors++;
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Read value from the register map rules
  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    logic [31:0] swapped;
    for (int i = 0; i < 4; i++) begin
      swapped[8*(3-i) +: 8] = model_scratch[8*i +: 8];
    end
    if (addr == hello_regs_pkg::hello_world_addr) return swapped;
    if (addr == hello_regs_pkg::vled_addr) return {16'h0000, model_scratch[15:0]};
    if (addr == hello_regs_pkg::design_id_addr) return exp_design_id;
    return exp_unimpl;
  endfunction

  task automatic issue_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    logic aw_done;
    logic w_done;
    logic aw_hs;
    logic w_hs;
    logic b_done;
    tick();
    ocl_awvalid <= 1'b1;
    ocl_awaddr  <= addr;
    ocl_wvalid  <= 1'b1;
    ocl_wdata   <= data;
    ocl_wstrb   <= strb;
    aw_done = 1'b0;
    w_done  = 1'b0;
    // Address and data channels complete independently
    while (!(aw_done && w_done)) begin
      @(negedge clk_main_a0);
      aw_hs = ocl_awvalid && ocl_awready;
      w_hs  = ocl_wvalid && ocl_wready;
      tick();
      if (aw_hs) begin
        ocl_awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        ocl_wvalid <= 1'b0;
        w_done = 1'b1;
      end
    end
    // Only the scratch word is writable
    if (addr == hello_regs_pkg::hello_world_addr) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) model_scratch[8*i +: 8] = data[8*i +: 8];
      end
    end
    b_done = 1'b0;
    while (!b_done) begin
      @(negedge clk_main_a0);
      if (ocl_bvalid && ocl_bready) begin
        b_done = 1'b1;
        check_value("bresp", {30'h0, ocl_bresp}, 32'h0);
      end
      tick();
    end
    @(negedge clk_main_a0);
    assert (!ocl_bvalid) else begin
      protocol_errors++;
      $display("A second write response followed the write to %h", addr);
    end
  endtask

  task automatic issue_read(input logic [31:0] addr);
    logic        ar_done;
    logic        r_done;
    logic        ar_hs;
    logic [31:0] exp;
    exp = expected_read(addr);
    tick();
    ocl_arvalid <= 1'b1;
    ocl_araddr  <= addr;
    ar_done = 1'b0;
    while (!ar_done) begin
      @(negedge clk_main_a0);
      ar_hs = ocl_arvalid && ocl_arready;
      tick();
      if (ar_hs) begin
        ocl_arvalid <= 1'b0;
        ar_done = 1'b1;
      end
    end
    r_done = 1'b0;
    while (!r_done) begin
      @(negedge clk_main_a0);
      if (ocl_rvalid && ocl_rready) begin
        r_done = 1'b1;
        check_value("rdata", ocl_rdata, exp);
        check_value("rresp", {30'h0, ocl_rresp}, 32'h0);
      end
      tick();
    end
    @(negedge clk_main_a0);
    assert (!ocl_rvalid) else begin
      protocol_errors++;
      $display("A second read data beat followed the read of %h", addr);
    end
  endtask

  // LEDs follow the masked model while the bus is idle
  task automatic idle_check();
    if ($urandom_range(0, 3) == 0) begin
      tick();
      status_vdip <= 16'($urandom());
    end
    @(negedge clk_main_a0);
    check_value("status_vled", {16'h0, status_vled}, {16'h0, model_scratch[15:0] & status_vdip});
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    logic [31:0] addr;
    void'($urandom(40408));
    rst_main_n_sync = 1'b0;
    ocl_awvalid     = 1'b0;
    ocl_awaddr      = '0;
    ocl_wvalid      = 1'b0;
    ocl_wdata       = '0;
    ocl_wstrb       = '0;
    ocl_bready      = 1'b0;
    ocl_arvalid     = 1'b0;
    ocl_araddr      = '0;
    ocl_rready      = 1'b0;
    status_vdip     = 16'hFFFF;
    data_errors     = 0;
    protocol_errors = 0;
    model_scratch   = '0;
    repeat (4) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    // Cleared scratch and dark LEDs right out of reset
    idle_check();
    issue_read(hello_regs_pkg::hello_world_addr);
    for (int n = 0; n < num_trans; n++) begin
      case ($urandom_range(0, 3))
        0: addr = hello_regs_pkg::hello_world_addr;
        1: addr = hello_regs_pkg::vled_addr;
        2: addr = hello_regs_pkg::design_id_addr;
        default: begin
          addr = $urandom();
          if (addr inside {hello_regs_pkg::hello_world_addr, hello_regs_pkg::vled_addr,
                           hello_regs_pkg::design_id_addr}) begin
            addr[12] = ~addr[12];
          end
        end
      endcase
      if ($urandom_range(0, 1) == 1) begin
        issue_write(addr, $urandom(), 4'($urandom()));
      end else begin
        issue_read(addr);
      end
      idle_check();
    end
    $display("Errors: %0d data, %0d protocol", data_errors, protocol_errors);
    if (data_errors == 0 && protocol_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the transaction count
  initial begin
    repeat (num_trans * cycles_per_trans) @(posedge clk_main_a0);
    $display("Timeout: traffic did not finish within %0d cycles", num_trans * cycles_per_trans);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
source/axil_pkg.sv
source/hello_regs_pkg.sv
source/axil_if.sv
source/reg_access_if.sv
source/axil_reg_slice.sv
source/axil_reg_slave.sv
source/hello_reg_file.sv
source/hello_world_top.sv
tb/hello_world_assertions.sv
tb/hello_world_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module hello_world_tb -f sources.f \
  && ./obj_dir/Vhello_world_tb > sim.log 2>&1 \
  || echo "Build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "^Test passed$" sim.log || { echo "Simulation did not pass"; exit 1; }
exit 0
